// File: source/lcd_pkg.sv
package lcd_pkg;

	typedef struct packed {
		logic       dc;   // 0 command, 1 data
		logic [7:0] data;
	} lcd_byte_t;

	// start stays high while bytes are pending
	typedef struct packed {
		logic      start;
		lcd_byte_t data_byte;
	} lcd_link_t;

	localparam int LCD_COLS  = 84;
	localparam int LCD_BANKS = 6; // 8 rows per bank

	localparam int LCD_CLEAR_BYTES = LCD_COLS * LCD_BANKS;
	localparam int LCD_CNT_W       = $clog2(LCD_CLEAR_BYTES);

	localparam logic [7:0] CMD_SET_X_BASE = 8'h80; // or'd with column
	localparam logic [7:0] CMD_SET_Y_BASE = 8'h40; // or'd with bank

	localparam int LCD_SETUP_N = 4;

	// extended set, contrast, basic set, normal display
	localparam logic [0:LCD_SETUP_N-1][7:0] LCD_SETUP_CMDS = {
		8'h21,
		8'h90,
		8'h20,
		8'h0C
	};

	typedef enum logic [1:0] {
		LINK_SETUP,
		LINK_CLEAR,
		LINK_RUN
	} link_state_e;

endpackage

// File: source/scene_pkg.sv
package scene_pkg;

	typedef enum logic [1:0] {
		SPR_HEART,
		SPR_SMILE,
		SPR_BONE
	} sprite_e;

	typedef struct packed {
		sprite_e    kind;
		logic       lit;  // blank slots draw zero columns
		logic [6:0] x;
		logic [2:0] bank;
	} draw_req_t;

	localparam int SLOTS_PER_ROW = 3;
	localparam int SLOT_PITCH    = 12;

	localparam int HEART_X0 = 2;
	localparam int SMILE_X0 = 50;
	localparam int BONE_X0  = 48;

	localparam int HEART_BANK = 1;
	localparam int SMILE_BANK = 1;
	localparam int BONE_BANK  = 4;

	localparam int HEART_W = 8;
	localparam int SMILE_W = 8;
	localparam int BONE_W  = 11;

	localparam int MAX_SPRITE_W = 11;
	localparam int COL_W        = $clog2(MAX_SPRITE_W + 1);

	function automatic logic [COL_W-1:0] sprite_width(input sprite_e kind);
		case (kind)
			SPR_HEART: return COL_W'(HEART_W);
			SPR_SMILE: return COL_W'(SMILE_W);
			default:   return COL_W'(BONE_W);
		endcase
	endfunction

	function automatic logic [6:0] sprite_x0(input sprite_e kind);
		case (kind)
			SPR_HEART: return 7'(HEART_X0);
			SPR_SMILE: return 7'(SMILE_X0);
			default:   return 7'(BONE_X0);
		endcase
	endfunction

	function automatic logic [2:0] sprite_bank(input sprite_e kind);
		case (kind)
			SPR_HEART: return 3'(HEART_BANK);
			SPR_SMILE: return 3'(SMILE_BANK);
			default:   return 3'(BONE_BANK);
		endcase
	endfunction

endpackage

// File: source/sprite_rom.sv
`timescale 1ns/10ps

module sprite_rom (
	input  scene_pkg::sprite_e          kind,
	input  logic [scene_pkg::COL_W-1:0] col,
	output logic [7:0]                  data
);
	import scene_pkg::*;

	// one byte per column, lsb is the top row of the bank
	always_comb begin
		case (kind)
			SPR_HEART: begin
				case (col)
					4'd0:    data = 8'h1E;
					4'd1:    data = 8'h3B;
					4'd2:    data = 8'h77;
					4'd3:    data = 8'hFE;
					4'd4:    data = 8'hFE;
					4'd5:    data = 8'h7F;
					4'd6:    data = 8'h3F;
					4'd7:    data = 8'h1E;
					default: data = 8'h00;
				endcase
			end
			SPR_SMILE: begin
				case (col)
					4'd0:    data = 8'h3C;
					4'd1:    data = 8'h42;
					4'd2:    data = 8'h95; // eyes
					4'd3:    data = 8'hA1;
					4'd4:    data = 8'hA1;
					4'd5:    data = 8'h95;
					4'd6:    data = 8'h42;
					4'd7:    data = 8'h3C;
					default: data = 8'h00;
				endcase
			end
			SPR_BONE: begin
				case (col)
					4'd0:    data = 8'h7C;
					4'd1:    data = 8'h92;
					4'd2:    data = 8'h82;
					4'd3:    data = 8'h6C;
					4'd4:    data = 8'h28; // shaft
					4'd5:    data = 8'h28;
					4'd6:    data = 8'h28;
					4'd7:    data = 8'h6C;
					4'd8:    data = 8'h82;
					4'd9:    data = 8'h92;
					4'd10:   data = 8'h7C;
					default: data = 8'h00;
				endcase
			end
			default: data = 8'h00;
		endcase
	end

endmodule

// File: source/sprite_drawer.sv
`timescale 1ns/10ps

module sprite_drawer (
	input  logic                        clock,
	input  logic                        rst,
	input  scene_pkg::draw_req_t        draw_req,
	input  logic                        draw_go,
	output scene_pkg::sprite_e          rom_kind,
	output logic [scene_pkg::COL_W-1:0] rom_col,
	input  logic [7:0]                  rom_data,
	input  logic                        avail,
	output lcd_pkg::lcd_link_t          link,
	output logic                        draw_done
);
	import lcd_pkg::*;
	import scene_pkg::*;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_X,
		PH_Y,
		PH_COL
	} phase_e;

	phase_e           phase;
	draw_req_t        req_q;
	logic [COL_W-1:0] col;
	logic [COL_W-1:0] width;
	logic             accept;
	logic             last_col;

	assign width    = sprite_width(req_q.kind);
	assign accept   = link.start && avail;
	assign last_col = (col == width - 1'b1);
	assign rom_kind = req_q.kind;
	assign rom_col  = col;

	always_ff @(posedge clock) begin
		if (rst) begin
			phase     <= PH_IDLE;
			draw_done <= 1'b0;
		end else begin
			draw_done <= 1'b0;
			case (phase)
				PH_IDLE: if (draw_go) phase <= PH_X;
				PH_X:    if (accept) phase <= PH_Y;
				PH_Y:    if (accept) phase <= PH_COL;
				PH_COL: begin
					if (accept && last_col) begin
						phase     <= PH_IDLE; // start drops with done
						draw_done <= 1'b1;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (phase == PH_IDLE && draw_go) begin
			req_q <= draw_req;
		end
		if (phase == PH_Y) begin
			col <= '0;
		end else if (phase == PH_COL && accept) begin
			col <= col + 1'b1;
		end
	end

	always_comb begin
		link.start        = (phase != PH_IDLE);
		link.data_byte.dc = (phase == PH_COL);
		case (phase)
			PH_X:    link.data_byte.data = CMD_SET_X_BASE | {1'b0, req_q.x};
			PH_Y:    link.data_byte.data = CMD_SET_Y_BASE | {5'b0, req_q.bank};
			PH_COL:  link.data_byte.data = req_q.lit ? rom_data : 8'h00;
			default: link.data_byte.data = 8'h00;
		endcase
	end

	// stepping past the width would spill into the next slot
	assert property (@(posedge clock) disable iff (rst)
		(phase == PH_COL) |-> (col < width));

endmodule

// File: source/scene_sequencer.sv
`timescale 1ns/10ps

module scene_sequencer (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 scene_enable,
	input  logic [1:0]           health,
	input  logic                 blink,
	input  logic                 draw_done,
	output scene_pkg::draw_req_t draw_req,
	output logic                 draw_go
);
	import scene_pkg::*;

	typedef enum logic [1:0] {
		SQ_IDLE,
		SQ_ISSUE,
		SQ_WAIT
	} seq_state_e;

	seq_state_e state;
	sprite_e    row;
	logic [1:0] slot;
	logic [1:0] health_q;
	logic       blink_q;
	logic       last_slot;
	logic       frame_start;

	assign last_slot = (slot == 2'(SLOTS_PER_ROW - 1));
	assign draw_go   = (state == SQ_ISSUE);

	// next request is heart slot 0
	assign frame_start = (state == SQ_IDLE && scene_enable) ||
		(state == SQ_WAIT && draw_done && last_slot && row == SPR_BONE);

	assign draw_req.kind = row;
	assign draw_req.lit  = (slot < health_q) && blink_q;
	assign draw_req.x    = sprite_x0(row) + 7'(slot * SLOT_PITCH);
	assign draw_req.bank = sprite_bank(row);

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= SQ_IDLE;
			row   <= SPR_HEART;
			slot  <= '0;
		end else begin
			case (state)
				SQ_IDLE:  if (scene_enable) state <= SQ_ISSUE;
				SQ_ISSUE: state <= SQ_WAIT;
				SQ_WAIT: begin
					if (draw_done) begin
						state <= SQ_ISSUE;
						if (last_slot) begin
							slot <= '0;
							case (row)
								SPR_HEART: row <= SPR_SMILE;
								SPR_SMILE: row <= SPR_BONE;
								default:   row <= SPR_HEART;
							endcase
						end else begin
							slot <= slot + 1'b1;
						end
					end
				end
				default: state <= SQ_IDLE;
			endcase
		end
	end

	// held for the whole frame
	always_ff @(posedge clock) begin
		if (frame_start) begin
			health_q <= health;
			blink_q  <= blink;
		end
	end

	// drawer needs at least X, Y and one column before done
	assert property (@(posedge clock) disable iff (rst)
		draw_go |=> !draw_done);

endmodule

// File: source/lcd_link_ctrl.sv
`timescale 1ns/10ps

module lcd_link_ctrl (
	input  logic               clock,
	input  logic               rst,
	input  logic               avail,
	input  lcd_pkg::lcd_link_t scene_link,
	output logic               scene_avail,
	output logic               scene_enable,
	output lcd_pkg::lcd_link_t link
);
	import lcd_pkg::*;

	link_state_e          state;
	logic [LCD_CNT_W-1:0] cnt;
	logic                 link_on; // low through reset
	logic                 accept;

	assign scene_enable = (state == LINK_RUN);
	assign scene_avail  = scene_enable && avail;
	assign accept       = link_on && avail;

	always_ff @(posedge clock) begin
		if (rst) begin
			state   <= LINK_SETUP;
			cnt     <= '0;
			link_on <= 1'b0;
		end else begin
			link_on <= 1'b1;
			case (state)
				LINK_SETUP: begin
					if (accept) begin
						if (cnt == LCD_CNT_W'(LCD_SETUP_N - 1)) begin
							state <= LINK_CLEAR;
							cnt   <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				LINK_CLEAR: begin
					if (accept) begin
						if (cnt == LCD_CNT_W'(LCD_CLEAR_BYTES - 1)) begin
							state <= LINK_RUN; // scene owns the link from here
							cnt   <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		case (state)
			LINK_SETUP: begin
				link.start     = link_on;
				link.data_byte = '{dc: 1'b0, data: LCD_SETUP_CMDS[cnt[1:0]]};
			end
			LINK_CLEAR: begin
				link.start     = link_on;
				link.data_byte = '{dc: 1'b1, data: 8'h00};
			end
			default: link = scene_link;
		endcase
	end

	// holds for setup, clear and the drawer behind the mux
	assert property (@(posedge clock) disable iff (rst)
		(link.start && !avail) |=> $stable(link.data_byte));

endmodule

// File: source/lcd_frame_top.sv
`timescale 1ns/10ps

module lcd_frame_top (
	input  logic               clock,
	input  logic               rst,
	input  logic [1:0]         health,
	input  logic               blink,
	input  logic               avail,
	output lcd_pkg::lcd_link_t link
);
	import lcd_pkg::*;
	import scene_pkg::*;

	lcd_link_t        scene_link;
	logic             scene_avail;
	logic             scene_enable;
	draw_req_t        draw_req;
	logic             draw_go;
	logic             draw_done;
	sprite_e          rom_kind;
	logic [COL_W-1:0] rom_col;
	logic [7:0]       rom_data;

	lcd_link_ctrl u_link_ctrl (
		.clock        (clock),
		.rst          (rst),
		.avail        (avail),
		.scene_link   (scene_link),
		.scene_avail  (scene_avail),
		.scene_enable (scene_enable),
		.link         (link)
	);

	scene_sequencer u_sequencer (
		.clock        (clock),
		.rst          (rst),
		.scene_enable (scene_enable),
		.health       (health),
		.blink        (blink),
		.draw_done    (draw_done),
		.draw_req     (draw_req),
		.draw_go      (draw_go)
	);

	sprite_drawer u_drawer (
		.clock     (clock),
		.rst       (rst),
		.draw_req  (draw_req),
		.draw_go   (draw_go),
		.rom_kind  (rom_kind),
		.rom_col   (rom_col),
		.rom_data  (rom_data),
		.avail     (scene_avail),
		.link      (scene_link),
		.draw_done (draw_done)
	);

	sprite_rom u_rom (
		.kind (rom_kind),
		.col  (rom_col),
		.data (rom_data)
	);

endmodule

// File: verif/lcd_frame_tb.sv
`timescale 1ns/10ps

module lcd_frame_tb;
	import lcd_pkg::*;

	localparam int FRAME_BYTES = 18 + 3 * (8 + 8 + 11);

	logic        clock;
	logic        rst;
	logic [1:0]  health;
	logic        blink;
	logic        avail;
	lcd_link_t   link;

	logic [31:0] trace_mem [0:63];
	logic [7:0]  ref_bytes [0:7][0:80]; // data bytes of the first frame per health and blink
	bit          ref_valid [0:7];
	logic [31:0] lfsr = 32'hfb2a_b3de;
	int          density = 8;           // avail chance out of 8
	int          errors = 0;
	int          passed = 0;
	int          failed = 0;
	int          ntests;
	int          watchdog_ns;
	bit          loaded = 0;
	bit          held = 0;
	lcd_byte_t   held_byte;
	int          row_x0 [0:2] = '{2, 50, 48};
	int          row_bank [0:2] = '{1, 1, 4};
	int          row_w [0:2] = '{8, 8, 11};
	int          setup_cmd [0:3] = '{'h21, 'h90, 'h20, 'h0c};

	lcd_frame_top DUT (.clock(clock), .rst(rst), .health(health), .blink(blink),
		.avail(avail), .link(link));

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	always @(posedge clock) begin
		logic [2:0] pick;
		int i;
		for (i = 0; i < 3; i++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			pick[i] = lfsr[0];
		end
		avail <= (int'(pick) < density);
	end

	// link must hold while stalled
	always @(negedge clock) begin
		if (rst && link.start !== 1'b0) begin
			errors++;
			$display("FAILED t=%0t link.start expected 0 got %b", $time, link.start);
		end else if (held && (link.start !== 1'b1 || link.data_byte !== held_byte)) begin
			errors++;
			$display("FAILED t=%0t link.data_byte expected %03h got %03h (start %b)",
				$time, held_byte, link.data_byte, link.start);
		end
		held = !rst && link.start && !avail;
		held_byte = link.data_byte;
	end

	task automatic expect_equal(input string name, input int exp, input int got);
		if (exp != got) begin
			errors++;
			$display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	task automatic get_byte(output logic dc, output logic [7:0] data);
		@(negedge clock);
		while (!(link.start && avail)) @(negedge clock);
		dc   = link.data_byte.dc;
		data = link.data_byte.data;
	endtask

	task automatic apply_test(input int t);
		int b;
		b = 1 + 6 * t;
		@(posedge clock);
		health  <= trace_mem[b][1:0];
		blink   <= trace_mem[b + 1][0];
		density <= trace_mem[b + 2];
	endtask

	task automatic run_frame(input int t, input bit switch_next);
		logic       dc;
		logic [7:0] d;
		int         r, s, c, n, lit_n, sum, key, base;
		bit         any;
		base = 1 + 6 * t;
		key = int'({trace_mem[base][1:0], trace_mem[base + 1][0]});
		n = 0;
		lit_n = 0;
		sum = 0;
		for (r = 0; r < 3; r++) begin
			for (s = 0; s < 3; s++) begin
				get_byte(dc, d);
				expect_equal("link.data_byte (x)", int'({1'b0, 8'h80 | 8'(row_x0[r] + s * 12)}),
					int'({dc, d}));
				get_byte(dc, d);
				expect_equal("link.data_byte (y)", int'({1'b0, 8'h40 | 8'(row_bank[r])}),
					int'({dc, d}));
				any = 1'b0;
				for (c = 0; c < row_w[r]; c++) begin
					get_byte(dc, d);
					expect_equal("link.data_byte.dc", 1, int'(dc));
					if (ref_valid[key])
						expect_equal("link.data_byte.data", int'(ref_bytes[key][n]), int'(d));
					else
						ref_bytes[key][n] = d;
					any |= (d != 8'h00);
					sum += int'(d);
					n++;
					if (switch_next && n == 40) apply_test(t + 1); // lands mid frame
				end
				if (any) lit_n++;
			end
		end
		ref_valid[key] = 1'b1;
		expect_equal("lit sprite count", trace_mem[base + 3], lit_n);
		expect_equal("frame data sum", trace_mem[base + 4], sum);
	endtask

	task automatic report_test(input string name, input int err0);
		if (errors == err0) begin
			passed++;
			$display("%s: pass", name);
		end else begin
			failed++;
			$display("%s: fail, %0d errors", name, errors - err0);
		end
	endtask

	initial begin
		int         t, f, i, err0, frames;
		logic       dc;
		logic [7:0] d;
		rst    <= 1'b1;
		health <= 2'd0;
		blink  <= 1'b0;
		avail  <= 1'b0;
		$readmemh("verif/lcd_frame_trace.txt", trace_mem);
		ntests = trace_mem[0];
		watchdog_ns = 4 + 504;
		for (t = 0; t < ntests; t++) watchdog_ns += int'(trace_mem[6 * t + 6]) * FRAME_BYTES;
		watchdog_ns = watchdog_ns * 32 * 4;
		loaded = 1'b1;
		apply_test(0);
		repeat (3) @(posedge clock);
		rst <= 1'b0;

		err0 = errors;
		for (i = 0; i < 4 + 504; i++) begin
			get_byte(dc, d);
			if (i < 4)
				expect_equal("link.data_byte (setup)", setup_cmd[i], int'({dc, d}));
			else
				expect_equal("link.data_byte (clear)", 'h100, int'({dc, d}));
		end
		report_test("setup and clear", err0);

		for (t = 0; t < ntests; t++) begin
			err0 = errors;
			frames = int'(trace_mem[6 * t + 6]);
			for (f = 0; f < frames; f++) run_frame(t, f == frames - 1 && t + 1 < ntests);
			report_test($sformatf("test %0d", t), err0);
		end

		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		wait (loaded);
		#(watchdog_ns);
		$display("timeout after %0d ns, the link stopped delivering bytes", watchdog_ns);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: lcd_frame.f
source/lcd_pkg.sv
source/scene_pkg.sv
source/sprite_rom.sv
source/sprite_drawer.sv
source/scene_sequencer.sv
source/lcd_link_ctrl.sv
source/lcd_frame_top.sv
verif/lcd_frame_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the lcd_frame testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps --top-module lcd_frame_tb \
	-f lcd_frame.f -o lcd_frame_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/lcd_frame_sim > sim.log 2>&1 \
	&& grep -qxF '*** PASSED ***' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// File: verif/lcd_frame_trace.txt
// first word is the number of tests, then one test per line
// health blink avail_density(of 8) lit_sprites data_sum frames
7
3 1 8 9 2280 2
1 1 2 3 0b80 2
2 1 3 6 1700 2
2 0 8 0 0000 1
0 1 5 0 0000 2
3 1 1 9 2280 1
1 1 8 3 0b80 1
